/* source/mmio_pkg.sv */
package mmio_pkg;

    localparam int WORD_BITS = 32;

    // data and address words share one width
    typedef logic [WORD_BITS-1:0] word_t;

    // kind of an accepted CPU request
    typedef enum logic [1:0] {
        REQ_READ  = 2'd0,  // data load
        REQ_FETCH = 2'd1,  // instruction fetch
        REQ_WRITE = 2'd2   // data store
    } req_kind_t;

    // where a request ends up after address decode
    typedef enum logic [2:0] {
        TGT_MEM       = 3'd0,  // low memory window
        TGT_SPI_CMD   = 3'd1,  // spi command and counter
        TGT_SPI_PARAM = 3'd2,  // spi parameter word
        TGT_I2C       = 3'd3,  // touch coordinates, read only
        TGT_NONE      = 3'd4   // unmapped, completes with zero
    } target_t;

endpackage

/* source/mmio_ctrl.sv */
module mmio_ctrl #(
    parameter int              MEM_WORDS      = 2048,
    parameter mmio_pkg::word_t SPI_CMD_ADDR   = 32'd121212,
    parameter mmio_pkg::word_t SPI_PARAM_ADDR = 32'd333333,
    parameter mmio_pkg::word_t I2C_ADDR       = 32'd923923
) (
    input  logic               clk,
    input  logic               nRst,
    // cpu side
    input  logic               read_i,
    input  logic               fetch_i,
    input  logic               write_i,
    input  mmio_pkg::word_t    addr_i,
    input  mmio_pkg::word_t    wdata_i,
    output logic               busy_o,
    output logic               done_o,
    output mmio_pkg::word_t    rdata_o,
    // memory bridge
    output logic               mem_start_o,
    output logic               mem_we_o,
    output mmio_pkg::word_t    mem_addr_o,
    output mmio_pkg::word_t    mem_wdata_o,
    input  logic               mem_done_i,
    input  mmio_pkg::word_t    mem_rdata_i,
    // peripheral bank
    output logic               per_start_o,
    output mmio_pkg::target_t  per_target_o,
    output mmio_pkg::word_t    per_wdata_o,
    input  logic               per_ready_i,
    input  logic               per_done_i,
    input  mmio_pkg::word_t    per_rdata_i
);
    import mmio_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ISSUE,  // waiting for the target to take the request
        ST_WAIT    // target busy, waiting for its done
    } state_t;

    state_t    state;
    req_kind_t kind_q;
    target_t   target_q;
    word_t     addr_q;
    word_t     wdata_q;

    logic      req_valid;
    req_kind_t req_kind;
    target_t   req_target;
    logic      tgt_mem;
    logic      tgt_done;
    logic      finish;
    word_t     resp_data;

    // strobe classification
    always_comb begin
        req_valid = 1'b1;
        req_kind  = REQ_READ;
        if (write_i) begin
            req_kind  = REQ_WRITE;
            req_valid = !(read_i || fetch_i); // write mixed with a read is dropped
        end else if (fetch_i) begin
            req_kind = REQ_FETCH;
        end else if (!read_i) begin
            req_valid = 1'b0;
        end
    end

    // address decode, direction matters for the fixed registers
    always_comb begin
        if (addr_i < word_t'(MEM_WORDS)) begin
            req_target = TGT_MEM;
        end else if (addr_i == SPI_CMD_ADDR) begin
            req_target = (req_kind == REQ_WRITE) ? TGT_SPI_CMD : TGT_NONE;
        end else if (addr_i == SPI_PARAM_ADDR) begin
            req_target = (req_kind == REQ_WRITE) ? TGT_SPI_PARAM : TGT_NONE;
        end else if (addr_i == I2C_ADDR) begin
            req_target = (req_kind == REQ_WRITE) ? TGT_NONE : TGT_I2C;
        end else begin
            req_target = TGT_NONE;
        end
    end

    assign tgt_mem  = (target_q == TGT_MEM);
    assign tgt_done = tgt_mem ? mem_done_i : per_done_i;

    // unmapped requests finish straight from issue
    assign finish = ((state == ST_ISSUE) && (target_q == TGT_NONE)) ||
                    ((state == ST_WAIT) && tgt_done);

    always_comb begin
        if ((kind_q == REQ_WRITE) || (target_q == TGT_NONE)) begin
            resp_data = '0;
        end else if (tgt_mem) begin
            resp_data = mem_rdata_i;
        end else begin
            resp_data = per_rdata_i;
        end
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state    <= ST_IDLE;
            kind_q   <= REQ_READ;
            target_q <= TGT_NONE;
            addr_q   <= '0;
            wdata_q  <= '0;
            busy_o   <= 1'b0;
            done_o   <= 1'b0;
            rdata_o  <= '0;
        end else begin
            done_o <= 1'b0; // single cycle pulse
            if (finish) begin
                state   <= ST_IDLE;
                busy_o  <= 1'b0;
                done_o  <= 1'b1;
                rdata_o <= resp_data;
            end else if ((state == ST_IDLE) && req_valid) begin
                state    <= ST_ISSUE;
                busy_o   <= 1'b1;
                kind_q   <= req_kind;
                target_q <= req_target;
                addr_q   <= addr_i;
                wdata_q  <= wdata_i;
            end else if ((state == ST_ISSUE) && (mem_start_o || per_start_o)) begin
                state <= ST_WAIT;
            end
        end
    end

    // bridge checks mem_busy itself, bank readiness is checked here
    assign mem_start_o = (state == ST_ISSUE) && tgt_mem;
    assign per_start_o = (state == ST_ISSUE) && !tgt_mem && (target_q != TGT_NONE) &&
                         per_ready_i;

    assign mem_we_o     = (kind_q == REQ_WRITE);
    assign mem_addr_o   = addr_q;
    assign mem_wdata_o  = wdata_q;
    assign per_target_o = target_q;
    assign per_wdata_o  = wdata_q;

endmodule

/* source/mem_bridge.sv */
module mem_bridge (
    input  logic            clk,
    input  logic            nRst,
    // from controller
    input  logic            mem_start_i,
    input  logic            mem_we_i,
    input  mmio_pkg::word_t mem_addr_i,
    input  mmio_pkg::word_t mem_wdata_i,
    output logic            mem_done_o,
    output mmio_pkg::word_t mem_rdata_o,
    // data memory bus
    input  mmio_pkg::word_t mem_rdata_i,
    input  logic            mem_busy_i,
    output mmio_pkg::word_t mem_addr_o,
    output mmio_pkg::word_t mem_wdata_o,
    output logic [3:0]      mem_sel_o,
    output logic            mem_read_o,
    output logic            mem_write_o
);

    typedef enum logic [1:0] {
        B_IDLE,
        B_ISSUE,  // bus still busy from the last access
        B_HOLD,   // strobe is on the bus this cycle
        B_WAIT    // memory working
    } bstate_t;

    bstate_t state;
    logic    we_q;
    logic    skip_q; // memory gets one cycle to raise busy

    assign mem_sel_o = 4'b1111; // always full words

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state       <= B_IDLE;
            we_q        <= 1'b0;
            skip_q      <= 1'b0;
            mem_addr_o  <= '0;
            mem_wdata_o <= '0;
            mem_rdata_o <= '0;
            mem_read_o  <= 1'b0;
            mem_write_o <= 1'b0;
            mem_done_o  <= 1'b0;
        end else begin
            mem_read_o  <= 1'b0;
            mem_write_o <= 1'b0;
            mem_done_o  <= 1'b0;
            case (state)
                B_IDLE: begin
                    if (mem_start_i) begin
                        state       <= B_ISSUE;
                        we_q        <= mem_we_i;
                        mem_addr_o  <= mem_addr_i;
                        mem_wdata_o <= mem_wdata_i;
                    end
                end
                B_ISSUE: begin
                    if (!mem_busy_i) begin
                        state       <= B_HOLD;
                        mem_read_o  <= !we_q;
                        mem_write_o <= we_q;
                    end
                end
                B_HOLD: begin
                    state  <= B_WAIT; // strobe drops by default
                    skip_q <= 1'b1;
                end
                B_WAIT: begin
                    if (skip_q) begin
                        skip_q <= 1'b0;
                    end else if (!mem_busy_i) begin
                        state      <= B_IDLE;
                        mem_done_o <= 1'b1;
                        if (!we_q) begin
                            mem_rdata_o <= mem_rdata_i;
                        end
                    end
                end
                default: state <= B_IDLE;
            endcase
        end
    end

endmodule

/* source/periph_bank.sv */
module periph_bank (
    input  logic              clk,
    input  logic              nRst,
    // from controller
    input  logic              per_start_i,
    input  mmio_pkg::target_t per_target_i,
    input  mmio_pkg::word_t   per_wdata_i,
    output logic              per_ready_o,
    output logic              per_done_o,
    output mmio_pkg::word_t   per_rdata_o,
    // spi engine
    input  logic              spi_busy_i,
    output logic [7:0]        spi_command_o,
    output logic [3:0]        spi_counter_o,
    output mmio_pkg::word_t   spi_params_o,
    output logic              spi_write_o,
    output logic              spi_enable_o,
    // i2c touch controller
    input  mmio_pkg::word_t   i2c_xy_i,
    input  logic              i2c_done_i,
    output logic              i2c_done_o
);
    import mmio_pkg::*;

    logic param_blocked;
    logic i2c_blocked;

    // only parameter writes and coordinate reads can stall
    assign param_blocked = (per_target_i == TGT_SPI_PARAM) && spi_busy_i;
    assign i2c_blocked   = (per_target_i == TGT_I2C) && !i2c_done_i;
    assign per_ready_o   = !(param_blocked || i2c_blocked);

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            per_done_o    <= 1'b0;
            per_rdata_o   <= '0;
            spi_command_o <= '0;
            spi_counter_o <= '0;
            spi_params_o  <= '0;
            spi_write_o   <= 1'b0;
            spi_enable_o  <= 1'b0;
            i2c_done_o    <= 1'b0;
        end else begin
            i2c_done_o  <= i2c_done_i;
            per_done_o  <= per_start_i;
            spi_write_o <= 1'b0;
            if (per_start_i) begin
                per_rdata_o <= '0;
                case (per_target_i)
                    TGT_SPI_CMD: begin
                        spi_command_o <= per_wdata_i[7:0];
                        spi_counter_o <= per_wdata_i[11:8];
                        spi_enable_o  <= 1'b0; // new command, engine idle
                    end
                    TGT_SPI_PARAM: begin
                        spi_params_o <= per_wdata_i;
                        spi_write_o  <= 1'b1;
                        spi_enable_o <= 1'b1; // held until next command
                    end
                    TGT_I2C: per_rdata_o <= i2c_xy_i;
                    default: per_rdata_o <= '0;
                endcase
            end
        end
    end

endmodule

/* source/mmio_top.sv */
module mmio_top #(
    parameter int              MEM_WORDS      = 2048,
    parameter mmio_pkg::word_t SPI_CMD_ADDR   = 32'd121212,
    parameter mmio_pkg::word_t SPI_PARAM_ADDR = 32'd333333,
    parameter mmio_pkg::word_t I2C_ADDR       = 32'd923923
) (
    input  logic            clk,
    input  logic            nRst,
    // cpu memory handler
    input  logic            read_i,
    input  logic            fetch_i,
    input  logic            write_i,
    input  mmio_pkg::word_t addr_i,
    input  mmio_pkg::word_t wdata_i,
    output logic            busy_o,
    output logic            done_o,
    output mmio_pkg::word_t rdata_o,
    // data memory
    output mmio_pkg::word_t mem_addr_o,
    output mmio_pkg::word_t mem_wdata_o,
    output logic [3:0]      mem_sel_o,
    output logic            mem_read_o,
    output logic            mem_write_o,
    input  mmio_pkg::word_t mem_rdata_i,
    input  logic            mem_busy_i,
    // spi
    input  logic            spi_busy_i,
    output logic [7:0]      spi_command_o,
    output logic [3:0]      spi_counter_o,
    output mmio_pkg::word_t spi_params_o,
    output logic            spi_write_o,
    output logic            spi_enable_o,
    // i2c
    input  mmio_pkg::word_t i2c_xy_i,
    input  logic            i2c_done_i,
    output logic            i2c_done_o
);
    import mmio_pkg::*;

    logic    mem_start;
    logic    mem_we;
    word_t   mem_addr;
    word_t   mem_wdata;
    logic    mem_done;
    word_t   mem_rdata;

    logic    per_start;
    target_t per_target;
    word_t   per_wdata;
    logic    per_ready;
    logic    per_done;
    word_t   per_rdata;

    mmio_ctrl #(
        .MEM_WORDS     (MEM_WORDS),
        .SPI_CMD_ADDR  (SPI_CMD_ADDR),
        .SPI_PARAM_ADDR(SPI_PARAM_ADDR),
        .I2C_ADDR      (I2C_ADDR)
    ) u_ctrl (
        .clk         (clk),
        .nRst        (nRst),
        .read_i      (read_i),
        .fetch_i     (fetch_i),
        .write_i     (write_i),
        .addr_i      (addr_i),
        .wdata_i     (wdata_i),
        .busy_o      (busy_o),
        .done_o      (done_o),
        .rdata_o     (rdata_o),
        .mem_start_o (mem_start),
        .mem_we_o    (mem_we),
        .mem_addr_o  (mem_addr),
        .mem_wdata_o (mem_wdata),
        .mem_done_i  (mem_done),
        .mem_rdata_i (mem_rdata),
        .per_start_o (per_start),
        .per_target_o(per_target),
        .per_wdata_o (per_wdata),
        .per_ready_i (per_ready),
        .per_done_i  (per_done),
        .per_rdata_i (per_rdata)
    );

    mem_bridge u_bridge (
        .clk        (clk),
        .nRst       (nRst),
        .mem_start_i(mem_start),
        .mem_we_i   (mem_we),
        .mem_addr_i (mem_addr),
        .mem_wdata_i(mem_wdata),
        .mem_done_o (mem_done),
        .mem_rdata_o(mem_rdata),
        .mem_rdata_i(mem_rdata_i),
        .mem_busy_i (mem_busy_i),
        .mem_addr_o (mem_addr_o),
        .mem_wdata_o(mem_wdata_o),
        .mem_sel_o  (mem_sel_o),
        .mem_read_o (mem_read_o),
        .mem_write_o(mem_write_o)
    );

    periph_bank u_bank (
        .clk          (clk),
        .nRst         (nRst),
        .per_start_i  (per_start),
        .per_target_i (per_target),
        .per_wdata_i  (per_wdata),
        .per_ready_o  (per_ready),
        .per_done_o   (per_done),
        .per_rdata_o  (per_rdata),
        .spi_busy_i   (spi_busy_i),
        .spi_command_o(spi_command_o),
        .spi_counter_o(spi_counter_o),
        .spi_params_o (spi_params_o),
        .spi_write_o  (spi_write_o),
        .spi_enable_o (spi_enable_o),
        .i2c_xy_i     (i2c_xy_i),
        .i2c_done_i   (i2c_done_i),
        .i2c_done_o   (i2c_done_o)
    );

endmodule

/* dv/tb_mem_model.sv */
module tb_mem_model (
    input  logic            clk,
    input  mmio_pkg::word_t mem_addr_i,
    input  mmio_pkg::word_t mem_wdata_i,
    input  logic            mem_read_i,
    input  logic            mem_write_i,
    output mmio_pkg::word_t mem_rdata_o,
    output logic            mem_busy_o
);
    timeunit 1ns;
    timeprecision 100ps;
    import mmio_pkg::*;

    word_t       mem [2048];
    logic [15:0] lfsr_q = 16'd54;
    int          stretch;

    // fibonacci lfsr, taps 16 14 13 11, one step per bit
    function automatic word_t rand_bits(input int n);
        word_t v;
        logic  fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            v      = {v[30:0], fb};
        end
        return v;
    endfunction

    initial begin
        for (int i = 0; i < 2048; i++) begin
            mem[i] = {~i[15:0], i[15:0]}; // every address bit shows up
        end
        stretch     = 0;
        mem_rdata_o = '0;
        mem_busy_o  = 1'b0;
    end

    // strobes are registered, so they are stable at the falling edge
    always @(negedge clk) begin
        if (mem_write_i || mem_read_i) begin
            if (mem_write_i) begin
                mem[mem_addr_i[10:0]] = mem_wdata_i;
            end else begin
                mem_rdata_o = mem[mem_addr_i[10:0]];
            end
            stretch = int'(rand_bits(2)); // 0 to 3 busy cycles
        end else if (stretch != 0) begin
            stretch--;
        end
        mem_busy_o = (stretch != 0);
    end

endmodule

/* dv/tb_mmio.sv */
module tb_mmio;
    timeunit 1ns;
    timeprecision 100ps;
    import mmio_pkg::*;

    localparam int    MEM_WORDS      = 2048;
    localparam word_t SPI_CMD_ADDR   = 32'd121212;
    localparam word_t SPI_PARAM_ADDR = 32'd333333;
    localparam word_t I2C_ADDR       = 32'd923923;
    localparam int    N_MEM          = 12;
    // about 40 requests of up to 12 cycles each, plus margin
    localparam int    MAX_CYCLES     = 2000;

    // what the current request is expected to do
    localparam int TAG_IDLE     = 0;
    localparam int TAG_MEM_WR   = 1;
    localparam int TAG_MEM_RD   = 2;
    localparam int TAG_CMD      = 3;
    localparam int TAG_PARAM    = 4;
    localparam int TAG_I2C      = 5;
    localparam int TAG_NONE     = 6;
    localparam int TAG_CONFLICT = 7;

    logic clk = 1'b0;
    logic nRst;
    logic read_i, fetch_i, write_i;
    word_t addr_i, wdata_i, rdata_o;
    logic busy_o, done_o;
    word_t mem_addr_o, mem_wdata_o, mem_rdata_i;
    logic [3:0] mem_sel_o;
    logic mem_read_o, mem_write_o, mem_busy_i;
    logic spi_busy_i, spi_write_o, spi_enable_o;
    logic [7:0] spi_command_o;
    logic [3:0] spi_counter_o;
    word_t spi_params_o, i2c_xy_i;
    logic i2c_done_i, i2c_done_o;

    int          tag;
    word_t       cur_addr, cur_wdata, exp_rdata;
    word_t       sb [word_t]; // expected memory contents
    word_t       addrs [$];
    logic [15:0] lfsr_q = 16'd54;
    int          errors = 0;
    int          tests = 0;
    int          cycles = 0;

    always #10 clk = ~clk;

    mmio_top #(
        .MEM_WORDS     (MEM_WORDS),
        .SPI_CMD_ADDR  (SPI_CMD_ADDR),
        .SPI_PARAM_ADDR(SPI_PARAM_ADDR),
        .I2C_ADDR      (I2C_ADDR)
    ) uut (.*);

    tb_mem_model u_mem (
        .clk        (clk),
        .mem_addr_i (mem_addr_o),
        .mem_wdata_i(mem_wdata_o),
        .mem_read_i (mem_read_o),
        .mem_write_i(mem_write_o),
        .mem_rdata_o(mem_rdata_i),
        .mem_busy_o (mem_busy_i)
    );

    function automatic word_t rand_bits(input int n);
        word_t v;
        logic  fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            v      = {v[30:0], fb};
        end
        return v;
    endfunction

    // reset values, checked while nRst is low
    a_reset: assert property (@(posedge clk) !nRst |-> !busy_o && !done_o && !mem_read_o &&
                              !mem_write_o && !spi_write_o && !spi_enable_o && rdata_o == 0)
        else begin errors++; $display("control outputs not low during reset"); end
    a_done_idle: assert property (@(posedge clk) disable iff (!nRst) done_o |-> !busy_o)
        else begin errors++; $display("busy_o still high at completion"); end
    a_rd_pulse: assert property (@(posedge clk) disable iff (!nRst) mem_read_o |=> !mem_read_o)
        else begin errors++; $display("mem_read_o longer than one cycle"); end
    a_wr_pulse: assert property (@(posedge clk) disable iff (!nRst) mem_write_o |=> !mem_write_o)
        else begin errors++; $display("mem_write_o longer than one cycle"); end
    a_bus_addr: assert property (@(posedge clk) disable iff (!nRst)
                                 (mem_read_o || mem_write_o) |-> mem_addr_o == cur_addr)
        else begin
            errors++;
            $display("ERR mem_addr_o got %h exp %h", $sampled(mem_addr_o), cur_addr);
        end
    a_bus_sel: assert property (@(posedge clk) disable iff (!nRst)
                                (mem_read_o || mem_write_o) |-> mem_sel_o == 4'hf)
        else begin
            errors++;
            $display("ERR mem_sel_o got %h exp %h", $sampled(mem_sel_o), 4'hf);
        end
    a_bus_wdata: assert property (@(posedge clk) disable iff (!nRst)
                                  mem_write_o |-> mem_wdata_o == cur_wdata)
        else begin
            errors++;
            $display("ERR mem_wdata_o got %h exp %h", $sampled(mem_wdata_o), cur_wdata);
        end
    a_rdata: assert property (@(posedge clk) disable iff (!nRst)
                              (done_o && (tag == TAG_MEM_RD || tag == TAG_I2C ||
                               tag == TAG_NONE)) |-> rdata_o == exp_rdata)
        else begin
            errors++;
            $display("ERR rdata_o got %h exp %h", $sampled(rdata_o), exp_rdata);
        end
    a_cmd_timing: assert property (@(posedge clk) disable iff (!nRst)
                                   (write_i && !read_i && !fetch_i && !busy_o &&
                                    addr_i == SPI_CMD_ADDR) |-> ##3 done_o)
        else begin errors++; $display("spi command write not done 3 cycles after strobe"); end
    a_cmd_regs: assert property (@(posedge clk) disable iff (!nRst)
                                 (done_o && tag == TAG_CMD) |->
                                 spi_command_o == cur_wdata[7:0] &&
                                 spi_counter_o == cur_wdata[11:8])
        else begin
            errors++;
            $display("ERR spi_command_o/spi_counter_o got %h/%h exp %h/%h",
                     $sampled(spi_command_o), $sampled(spi_counter_o),
                     cur_wdata[7:0], cur_wdata[11:8]);
        end
    a_cmd_enable: assert property (@(posedge clk) disable iff (!nRst)
                                   (done_o && tag == TAG_CMD) |-> !spi_enable_o)
        else begin errors++; $display("spi_enable_o still high after a command write"); end
    a_no_write_busy: assert property (@(posedge clk) disable iff (!nRst)
                                      spi_busy_i |-> !spi_write_o && !(done_o && tag == TAG_PARAM))
        else begin errors++; $display("spi parameter write went through while busy"); end
    a_spi_pulse: assert property (@(posedge clk) disable iff (!nRst) spi_write_o |=> !spi_write_o)
        else begin errors++; $display("spi_write_o longer than one cycle"); end
    a_param_regs: assert property (@(posedge clk) disable iff (!nRst)
                                   (done_o && tag == TAG_PARAM) |-> spi_params_o == cur_wdata)
        else begin
            errors++;
            $display("ERR spi_params_o got %h exp %h", $sampled(spi_params_o), cur_wdata);
        end
    a_param_ctrl: assert property (@(posedge clk) disable iff (!nRst)
                                   (done_o && tag == TAG_PARAM) |->
                                   spi_enable_o && $past(spi_write_o))
        else begin errors++; $display("parameter write gave no write pulse or no enable"); end
    a_i2c_wait: assert property (@(posedge clk) disable iff (!nRst)
                                 (done_o && tag == TAG_I2C) |-> $past(i2c_done_i, 2))
        else begin errors++; $display("i2c read finished before i2c_done_i"); end
    a_i2c_echo: assert property (@(posedge clk) disable iff (!nRst)
                                 i2c_done_o == $past(i2c_done_i))
        else begin errors++; $display("i2c_done_o does not follow i2c_done_i"); end
    a_none_bus: assert property (@(posedge clk) disable iff (!nRst)
                                 (tag == TAG_NONE || tag == TAG_CONFLICT) |->
                                 !mem_read_o && !mem_write_o)
        else begin errors++; $display("memory strobe for an unmapped request"); end
    a_conflict: assert property (@(posedge clk) disable iff (!nRst)
                                 tag == TAG_CONFLICT |-> !busy_o && !done_o)
        else begin errors++; $display("conflicting request was accepted"); end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, request never completed", cycles);
            $display("TB FAILED");
            $finish;
        end
    end

    // one strobe cycle, inputs change on the falling edge
    task automatic send(input logic rd, input logic fe, input logic wr, input word_t addr,
                        input word_t data, input int req_tag, input word_t exp);
        @(negedge clk);
        tag       = req_tag;
        cur_addr  = addr;
        cur_wdata = data;
        exp_rdata = exp;
        read_i    = rd;
        fetch_i   = fe;
        write_i   = wr;
        addr_i    = addr;
        wdata_i   = data;
        @(negedge clk);
        read_i  = 1'b0;
        fetch_i = 1'b0;
        write_i = 1'b0;
    endtask

    task automatic wait_done();
        while (!done_o) @(negedge clk);
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %0d %s finished, errors so far %0d", tests, name, errors);
    endtask

    initial begin
        word_t a;
        word_t d;
        nRst       = 1'b0;
        read_i     = 1'b0;
        fetch_i    = 1'b0;
        write_i    = 1'b0;
        addr_i     = '0;
        wdata_i    = '0;
        spi_busy_i = 1'b0;
        i2c_xy_i   = '0;
        i2c_done_i = 1'b0;
        tag        = TAG_IDLE;
        cur_addr   = '0;
        cur_wdata  = '0;
        exp_rdata  = '0;
        repeat (4) @(negedge clk);
        nRst = 1'b1;
        end_test("reset state");

        for (int i = 0; i < N_MEM; i++) begin
            a = rand_bits(11); // always inside the memory window
            d = rand_bits(32);
            sb[a] = d;
            addrs.push_back(a);
            send(1'b0, 1'b0, 1'b1, a, d, TAG_MEM_WR, '0);
            wait_done();
        end
        for (int i = 0; i < N_MEM; i++) begin
            a = addrs[N_MEM-1-i];
            send(i[0] == 1'b0, i[0] == 1'b1, 1'b0, a, '0, TAG_MEM_RD, sb[a]);
            wait_done();
        end
        end_test("memory round trip");

        d = rand_bits(32);
        send(1'b0, 1'b0, 1'b1, SPI_CMD_ADDR, d, TAG_CMD, '0);
        wait_done();
        end_test("spi command");

        spi_busy_i = 1'b1;
        d = rand_bits(32);
        send(1'b0, 1'b0, 1'b1, SPI_PARAM_ADDR, d, TAG_PARAM, '0);
        repeat (6) @(negedge clk);
        spi_busy_i = 1'b0;
        wait_done();
        end_test("spi parameter with busy");

        // enable is high now, a new command has to drop it
        d = rand_bits(32);
        send(1'b0, 1'b0, 1'b1, SPI_CMD_ADDR, d, TAG_CMD, '0);
        wait_done();
        end_test("spi command after parameter");

        i2c_xy_i = rand_bits(32);
        send(1'b1, 1'b0, 1'b0, I2C_ADDR, '0, TAG_I2C, i2c_xy_i);
        repeat (5) @(negedge clk);
        i2c_done_i = 1'b1;
        wait_done();
        @(negedge clk);
        i2c_done_i = 1'b0;
        end_test("i2c read");

        send(1'b1, 1'b0, 1'b0, 32'd5000, '0, TAG_NONE, '0);
        wait_done();
        send(1'b0, 1'b1, 1'b0, SPI_CMD_ADDR, '0, TAG_NONE, '0);
        wait_done();
        send(1'b1, 1'b0, 1'b1, 32'd16, 32'h1234, TAG_CONFLICT, '0);
        repeat (5) @(negedge clk);
        tag = TAG_IDLE;
        end_test("unmapped and conflict");

        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* list.f */
source/mmio_pkg.sv
source/mmio_ctrl.sv
source/mem_bridge.sv
source/periph_bank.sv
source/mmio_top.sv
dv/tb_mem_model.sv
dv/tb_mmio.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_mmio -f list.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_mmio)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "TB PASSED"; then
    exit 0
else
    exit 1
fi
